/* include/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// store queue size
`define LSU_SQ_DEPTH 8
`define LSU_SQ_LOG 3        // log2 of sq depth

// load queue size
`define LSU_LQ_DEPTH 8
`define LSU_LQ_LOG 3        // log2 of lq depth

// word address, full words only
`define LSU_ADDR_BITS 32

// load and store data
`define LSU_DATA_BITS 32

`endif

/* verilog/lsuPkg.sv */
`default_nettype none

package lsuPkg;
	`include "lsu_defs.svh"

	// memory op carried on dispatch and agen
	typedef enum logic {
		opLoad,
		opStore
	} lsuOp_e;

	// store entry life cycle
	typedef enum logic [1:0] {
		entryFree,      // not allocated
		entryWaiting,   // dispatched, addr unknown
		entryReady      // addr and data captured
	} sqState_e;

	typedef logic [`LSU_SQ_LOG-1:0]    sqIdx_t;
	typedef logic [`LSU_LQ_LOG-1:0]    lqIdx_t;
	typedef logic [`LSU_SQ_LOG:0]      lsqCount_t;  // 0..depth
	typedef logic [`LSU_SQ_DEPTH-1:0]  sqMask_t;    // one bit per store entry
	typedef logic [`LSU_ADDR_BITS-1:0] addr_t;
	typedef logic [`LSU_DATA_BITS-1:0] data_t;
endpackage

`default_nettype wire

/* verilog/lsuControl.sv */
`default_nettype none
`include "lsu_defs.svh"

module lsuControl (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    recoverFlag_i,
	input  wire                    dispatchValid_i,
	input  wire lsuPkg::lsuOp_e    dispatchOp_i,
	input  wire                    commitLoad_i,
	input  wire                    commitStore_i,
	output lsuPkg::sqIdx_t         lsqId_o,
	output logic                   lqAlloc_o,
	output lsuPkg::lqIdx_t         lqAllocIdx_o,
	output logic                   sqAlloc_o,
	output lsuPkg::sqIdx_t         sqAllocIdx_o,
	output logic                   lqRetire_o,
	output lsuPkg::lqIdx_t         lqRetireIdx_o,
	output logic                   sqRetire_o,
	output lsuPkg::sqIdx_t         sqRetireIdx_o,
	output logic                   recover_o,
	output lsuPkg::lsqCount_t      ldqCount_o,
	output lsuPkg::lsqCount_t      stqCount_o
);
	import lsuPkg::*;

	lqIdx_t    lqHead;      // oldest load
	lqIdx_t    lqTail;      // next free load slot
	sqIdx_t    sqHead;      // oldest store
	sqIdx_t    sqTail;      // next free store slot
	lsqCount_t ldqCount;
	lsqCount_t stqCount;

	// id handed back in the dispatch cycle itself
	assign lsqId_o = (dispatchOp_i == opStore) ? sqTail : lqTail;

	// a dispatch racing a recovery is squashed
	assign lqAlloc_o    = dispatchValid_i && (dispatchOp_i == opLoad) && !recoverFlag_i;
	assign sqAlloc_o    = dispatchValid_i && (dispatchOp_i == opStore) && !recoverFlag_i;
	assign lqAllocIdx_o = lqTail;
	assign sqAllocIdx_o = sqTail;   // also the scan start for forwarding

	// commit is older than any recovery, so it still goes through
	assign lqRetire_o    = commitLoad_i;
	assign lqRetireIdx_o = lqHead;  // doubles as lq head for vio search
	assign sqRetire_o    = commitStore_i;
	assign sqRetireIdx_o = sqHead;

	assign recover_o  = recoverFlag_i;
	assign ldqCount_o = ldqCount;
	assign stqCount_o = stqCount;

	always_ff @(posedge clk)
	begin
		if (reset || recoverFlag_i)
		begin
			// both queues drained
			lqHead   <= '0;
			lqTail   <= '0;
			sqHead   <= '0;
			sqTail   <= '0;
			ldqCount <= '0;
			stqCount <= '0;
		end
		else
		begin
			if (lqAlloc_o)
				lqTail <= lqTail + lqIdx_t'(1);   // wraps at depth
			if (lqRetire_o)
				lqHead <= lqHead + lqIdx_t'(1);
			if (sqAlloc_o)
				sqTail <= sqTail + sqIdx_t'(1);
			if (sqRetire_o)
				sqHead <= sqHead + sqIdx_t'(1);

			// alloc and retire together leave count alone
			if (lqAlloc_o && !lqRetire_o)
				ldqCount <= ldqCount + lsqCount_t'(1);
			else if (lqRetire_o && !lqAlloc_o)
				ldqCount <= ldqCount - lsqCount_t'(1);

			if (sqAlloc_o && !sqRetire_o)
				stqCount <= stqCount + lsqCount_t'(1);
			else if (sqRetire_o && !sqAlloc_o)
				stqCount <= stqCount - lsqCount_t'(1);
		end
	end

	// no back-pressure, dispatcher must watch the counts
	dispatchNotFull: assert property (@(posedge clk) disable iff (reset)
		dispatchValid_i |-> ((dispatchOp_i == opLoad) ?
			(ldqCount != lsqCount_t'(`LSU_LQ_DEPTH)) :
			(stqCount != lsqCount_t'(`LSU_SQ_DEPTH))))
		else $error("lsuControl: dispatch into a full queue");

	commitNotEmpty: assert property (@(posedge clk) disable iff (reset)
		!(commitLoad_i && (ldqCount == '0)) && !(commitStore_i && (stqCount == '0)))
		else $error("lsuControl: commit from an empty queue");
endmodule

`default_nettype wire

/* verilog/storeQueue.sv */
`default_nettype none
`include "lsu_defs.svh"

module storeQueue (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    sqAlloc_i,
	input  wire lsuPkg::sqIdx_t    sqAllocIdx_i,
	input  wire                    sqRetire_i,
	input  wire lsuPkg::sqIdx_t    sqRetireIdx_i,
	input  wire lsuPkg::sqIdx_t    sqTail_i,
	input  wire                    recover_i,
	input  wire                    memValid_i,
	input  wire lsuPkg::lsuOp_e    memOp_i,
	input  wire lsuPkg::sqIdx_t    memLsqId_i,
	input  wire lsuPkg::addr_t     memAddr_i,
	input  wire lsuPkg::data_t     memData_i,
	input  wire lsuPkg::sqMask_t   fwdMask_i,
	output lsuPkg::sqMask_t        sqOccupied_o,
	output logic                   stResolved_o,
	output lsuPkg::sqIdx_t         stResolvedIdx_o,
	output lsuPkg::addr_t          stResolvedAddr_o,
	output logic                   fwdHit_o,
	output lsuPkg::data_t          fwdData_o,
	output logic                   stEn_o,
	output lsuPkg::addr_t          stAddr_o,
	output lsuPkg::data_t          stData_o
);
	import lsuPkg::*;

	sqState_e sqState [`LSU_SQ_DEPTH];
	addr_t    sqAddr  [`LSU_SQ_DEPTH];
	data_t    sqData  [`LSU_SQ_DEPTH];
	logic     ldArrive;     // agen hands us a load
	logic     stArrive;     // agen hands us a store
	sqMask_t  addrMatch;    // older, ready and same word
	sqIdx_t   fwdIdx;

	assign ldArrive = memValid_i && (memOp_i == opLoad);
	assign stArrive = memValid_i && (memOp_i == opStore);

	// store addr now known, lq checks for early loads
	assign stResolved_o     = stArrive && !recover_i;
	assign stResolvedIdx_o  = memLsqId_i;
	assign stResolvedAddr_o = memAddr_i;

	always_comb
	begin
		for (int i = 0; i < `LSU_SQ_DEPTH; i++)
		begin
			sqOccupied_o[i] = (sqState[i] != entryFree);
			// waiting stores are skipped, load goes ahead speculatively
			addrMatch[i] = fwdMask_i[i] && (sqState[i] == entryReady) &&
				(sqAddr[i] == memAddr_i);
		end
	end

	// walk back from tail, first hit is the youngest older store
	always_comb
	begin
		sqIdx_t idx;
		logic   found;
		found  = 1'b0;
		fwdIdx = sqTail_i;
		for (int k = 1; k <= `LSU_SQ_DEPTH; k++)
		begin
			idx = sqTail_i - sqIdx_t'(k);   // k = depth lands on tail again, full queue
			if (!found && addrMatch[idx])
			begin
				found  = 1'b1;
				fwdIdx = idx;
			end
		end
		fwdHit_o = found && ldArrive;
	end

	assign fwdData_o = sqData[fwdIdx];

	always_ff @(posedge clk)
	begin
		if (reset || recover_i)
		begin
			for (int i = 0; i < `LSU_SQ_DEPTH; i++)
				sqState[i] <= entryFree;
		end
		else
		begin
			if (sqAlloc_i)
				sqState[sqAllocIdx_i] <= entryWaiting;
			if (stArrive)
				sqState[memLsqId_i] <= entryReady;
			if (sqRetire_i)
				sqState[sqRetireIdx_i] <= entryFree;   // head leaves
		end
	end

	always_ff @(posedge clk)
	begin
		if (stArrive)
		begin
			sqAddr[memLsqId_i] <= memAddr_i;
			sqData[memLsqId_i] <= memData_i;
		end
	end

	// write to memory one cycle after commit
	always_ff @(posedge clk)
	begin
		if (reset)
			stEn_o <= 1'b0;
		else
			stEn_o <= sqRetire_i;
	end

	always_ff @(posedge clk)
	begin
		if (sqRetire_i)
		begin
			stAddr_o <= sqAddr[sqRetireIdx_i];
			stData_o <= sqData[sqRetireIdx_i];
		end
	end

	// head must have its addr and data before commit
	commitReady: assert property (@(posedge clk) disable iff (reset)
		sqRetire_i |-> (sqState[sqRetireIdx_i] == entryReady))
		else $error("storeQueue: commit of a store without address");

	// agen sends a store once, after dispatch
	arriveOnce: assert property (@(posedge clk) disable iff (reset || recover_i)
		stArrive |-> (sqState[memLsqId_i] == entryWaiting))
		else $error("storeQueue: store arrival for an entry not waiting");
endmodule

`default_nettype wire

/* verilog/loadQueue.sv */
`default_nettype none
`include "lsu_defs.svh"

module loadQueue (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    lqAlloc_i,
	input  wire lsuPkg::lqIdx_t    lqAllocIdx_i,
	input  wire                    lqRetire_i,
	input  wire lsuPkg::lqIdx_t    lqRetireIdx_i,
	input  wire                    recover_i,
	input  wire lsuPkg::sqMask_t   sqOccupied_i,
	input  wire                    memValid_i,
	input  wire lsuPkg::lsuOp_e    memOp_i,
	input  wire lsuPkg::sqIdx_t    memLsqId_i,
	input  wire lsuPkg::addr_t     memAddr_i,
	input  wire                    stResolved_i,
	input  wire lsuPkg::sqIdx_t    stResolvedIdx_i,
	input  wire lsuPkg::addr_t     stResolvedAddr_i,
	input  wire                    sqRetire_i,
	input  wire lsuPkg::sqIdx_t    sqRetireIdx_i,
	output lsuPkg::sqMask_t        fwdMask_o,
	output logic                   ldVioValid_o,
	output lsuPkg::lqIdx_t         ldVioLsqId_o
);
	import lsuPkg::*;

	sqMask_t                  lqOlder [`LSU_LQ_DEPTH];  // stores ahead of each load
	addr_t                    lqAddr  [`LSU_LQ_DEPTH];
	logic [`LSU_LQ_DEPTH-1:0] lqExec;     // load has gone down the pipe
	sqMask_t                  retireMask;
	logic [`LSU_LQ_DEPTH-1:0] vioMatch;
	logic                     vioFound;
	lqIdx_t                   vioIdx;
	logic                     ldArrive;

	assign ldArrive = memValid_i && (memOp_i == opLoad);

	// one-hot of the store leaving the sq this cycle
	assign retireMask = sqRetire_i ? (sqMask_t'(1) << sqRetireIdx_i) : '0;

	// older stores of the arriving load, for the sq search
	assign fwdMask_o = lqOlder[memLsqId_i];

	always_comb
	begin
		for (int j = 0; j < `LSU_LQ_DEPTH; j++)
			vioMatch[j] = lqExec[j] && lqOlder[j][stResolvedIdx_i] &&
				(lqAddr[j] == stResolvedAddr_i);
	end

	// oldest offending load first, scan from head
	always_comb
	begin
		lqIdx_t idx;
		vioFound = 1'b0;
		vioIdx   = lqRetireIdx_i;
		for (int k = 0; k < `LSU_LQ_DEPTH; k++)
		begin
			idx = lqRetireIdx_i + lqIdx_t'(k);
			if (!vioFound && vioMatch[idx])
			begin
				vioFound = 1'b1;
				vioIdx   = idx;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset || recover_i)
			lqExec <= '0;
		else
		begin
			if (lqAlloc_i)
				lqExec[lqAllocIdx_i] <= 1'b0;
			if (ldArrive)
				lqExec[memLsqId_i] <= 1'b1;
			if (lqRetire_i)
				lqExec[lqRetireIdx_i] <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		// committed store no longer older than anyone
		for (int j = 0; j < `LSU_LQ_DEPTH; j++)
			lqOlder[j] <= lqOlder[j] & ~retireMask;
		if (lqAlloc_i)
			lqOlder[lqAllocIdx_i] <= sqOccupied_i & ~retireMask;  // snapshot at dispatch
		if (ldArrive)
			lqAddr[memLsqId_i] <= memAddr_i;
	end

	// flag shows up the cycle after the store's agen
	always_ff @(posedge clk)
	begin
		if (reset)
			ldVioValid_o <= 1'b0;
		else
			ldVioValid_o <= stResolved_i && vioFound && !recover_i;
	end

	always_ff @(posedge clk)
	begin
		if (vioFound)
			ldVioLsqId_o <= vioIdx;
	end
endmodule

`default_nettype wire

/* verilog/loadPipe.sv */
`default_nettype none
`include "lsu_defs.svh"

module loadPipe (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    recover_i,
	input  wire                    memValid_i,
	input  wire lsuPkg::lsuOp_e    memOp_i,
	input  wire lsuPkg::sqIdx_t    memLsqId_i,
	input  wire lsuPkg::addr_t     memAddr_i,
	input  wire                    fwdHit_i,
	input  wire lsuPkg::data_t     fwdData_i,
	input  wire lsuPkg::data_t     ldData_i,
	output logic                   ldEn_o,
	output lsuPkg::addr_t          ldAddr_o,
	output logic                   wbValid_o,
	output lsuPkg::lqIdx_t         wbLsqId_o,
	output lsuPkg::data_t          wbData_o
);
	import lsuPkg::*;

	logic   s1Valid;    // stage 1, memory read in flight
	lqIdx_t s1Id;
	logic   s1FwdHit;
	data_t  s1FwdData;
	logic   s2Valid;    // stage 2, memory data back
	logic   s2FwdHit;
	data_t  s2FwdData;

	always_ff @(posedge clk)
	begin
		if (reset || recover_i)
		begin
			s1Valid <= 1'b0;    // in-flight loads dropped
			s2Valid <= 1'b0;
		end
		else
		begin
			s1Valid <= memValid_i && (memOp_i == opLoad);
			s2Valid <= s1Valid;
		end
	end

	always_ff @(posedge clk)
	begin
		s1Id      <= memLsqId_i;
		ldAddr_o  <= memAddr_i;
		s1FwdHit  <= fwdHit_i;     // sq search done in the agen cycle
		s1FwdData <= fwdData_i;
		wbLsqId_o <= s1Id;
		s2FwdHit  <= s1FwdHit;
		s2FwdData <= s1FwdData;
	end

	assign ldEn_o    = s1Valid;   // read issued from stage 1
	assign wbValid_o = s2Valid;

	// store data wins over the memory word
	assign wbData_o = s2FwdHit ? s2FwdData : ldData_i;
endmodule

`default_nettype wire

/* verilog/loadStoreUnit.sv */
`default_nettype none
`include "lsu_defs.svh"

module loadStoreUnit (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    recoverFlag_i,
	input  wire                    dispatchValid_i,
	input  wire lsuPkg::lsuOp_e    dispatchOp_i,
	output lsuPkg::sqIdx_t         lsqId_o,
	input  wire                    memValid_i,
	input  wire lsuPkg::lsuOp_e    memOp_i,
	input  wire lsuPkg::sqIdx_t    memLsqId_i,
	input  wire lsuPkg::addr_t     memAddr_i,
	input  wire lsuPkg::data_t     memData_i,
	input  wire                    commitLoad_i,
	input  wire                    commitStore_i,
	output logic                   ldEn_o,
	output lsuPkg::addr_t          ldAddr_o,
	input  wire lsuPkg::data_t     ldData_i,
	output logic                   stEn_o,
	output lsuPkg::addr_t          stAddr_o,
	output lsuPkg::data_t          stData_o,
	output logic                   wbValid_o,
	output lsuPkg::lqIdx_t         wbLsqId_o,
	output lsuPkg::data_t          wbData_o,
	output logic                   ldVioValid_o,
	output lsuPkg::lqIdx_t         ldVioLsqId_o,
	output lsuPkg::lsqCount_t      ldqCount_o,
	output lsuPkg::lsqCount_t      stqCount_o
);
	import lsuPkg::*;

	// control to datapath
	logic    lqAlloc;
	lqIdx_t  lqAllocIdx;
	logic    sqAlloc;
	sqIdx_t  sqAllocIdx;    // sq tail as well
	logic    lqRetire;
	lqIdx_t  lqRetireIdx;   // lq head as well
	logic    sqRetire;
	sqIdx_t  sqRetireIdx;
	logic    recover;

	// between the queues and the pipe
	sqMask_t sqOccupied;
	sqMask_t fwdMask;
	logic    stResolved;
	sqIdx_t  stResolvedIdx;
	addr_t   stResolvedAddr;
	logic    fwdHit;
	data_t   fwdData;

	lsuControl control (
		.clk             (clk),
		.reset           (reset),
		.recoverFlag_i   (recoverFlag_i),
		.dispatchValid_i (dispatchValid_i),
		.dispatchOp_i    (dispatchOp_i),
		.commitLoad_i    (commitLoad_i),
		.commitStore_i   (commitStore_i),
		.lsqId_o         (lsqId_o),
		.lqAlloc_o       (lqAlloc),
		.lqAllocIdx_o    (lqAllocIdx),
		.sqAlloc_o       (sqAlloc),
		.sqAllocIdx_o    (sqAllocIdx),
		.lqRetire_o      (lqRetire),
		.lqRetireIdx_o   (lqRetireIdx),
		.sqRetire_o      (sqRetire),
		.sqRetireIdx_o   (sqRetireIdx),
		.recover_o       (recover),
		.ldqCount_o      (ldqCount_o),
		.stqCount_o      (stqCount_o)
	);

	storeQueue stq (
		.clk              (clk),
		.reset            (reset),
		.sqAlloc_i        (sqAlloc),
		.sqAllocIdx_i     (sqAllocIdx),
		.sqRetire_i       (sqRetire),
		.sqRetireIdx_i    (sqRetireIdx),
		.sqTail_i         (sqAllocIdx),
		.recover_i        (recover),
		.memValid_i       (memValid_i),
		.memOp_i          (memOp_i),
		.memLsqId_i       (memLsqId_i),
		.memAddr_i        (memAddr_i),
		.memData_i        (memData_i),
		.fwdMask_i        (fwdMask),
		.sqOccupied_o     (sqOccupied),
		.stResolved_o     (stResolved),
		.stResolvedIdx_o  (stResolvedIdx),
		.stResolvedAddr_o (stResolvedAddr),
		.fwdHit_o         (fwdHit),
		.fwdData_o        (fwdData),
		.stEn_o           (stEn_o),
		.stAddr_o         (stAddr_o),
		.stData_o         (stData_o)
	);

	loadQueue ldq (
		.clk              (clk),
		.reset            (reset),
		.lqAlloc_i        (lqAlloc),
		.lqAllocIdx_i     (lqAllocIdx),
		.lqRetire_i       (lqRetire),
		.lqRetireIdx_i    (lqRetireIdx),
		.recover_i        (recover),
		.sqOccupied_i     (sqOccupied),
		.memValid_i       (memValid_i),
		.memOp_i          (memOp_i),
		.memLsqId_i       (memLsqId_i),
		.memAddr_i        (memAddr_i),
		.stResolved_i     (stResolved),
		.stResolvedIdx_i  (stResolvedIdx),
		.stResolvedAddr_i (stResolvedAddr),
		.sqRetire_i       (sqRetire),
		.sqRetireIdx_i    (sqRetireIdx),
		.fwdMask_o        (fwdMask),
		.ldVioValid_o     (ldVioValid_o),
		.ldVioLsqId_o     (ldVioLsqId_o)
	);

	loadPipe pipe (
		.clk        (clk),
		.reset      (reset),
		.recover_i  (recover),
		.memValid_i (memValid_i),
		.memOp_i    (memOp_i),
		.memLsqId_i (memLsqId_i),
		.memAddr_i  (memAddr_i),
		.fwdHit_i   (fwdHit),
		.fwdData_i  (fwdData),
		.ldData_i   (ldData_i),
		.ldEn_o     (ldEn_o),
		.ldAddr_o   (ldAddr_o),
		.wbValid_o  (wbValid_o),
		.wbLsqId_o  (wbLsqId_o),
		.wbData_o   (wbData_o)
	);
endmodule

`default_nettype wire

/* tests/lsuTb.sv */
`default_nettype none
`include "lsu_defs.svh"

module lsuTb;
	timeunit 1ns;
	timeprecision 1ps;
	import lsuPkg::*;

	logic      clk = 1'b0;
	logic      reset;
	logic      recoverFlag_i;
	logic      dispatchValid_i;
	lsuOp_e    dispatchOp_i;
	sqIdx_t    lsqId_o;
	logic      memValid_i;
	lsuOp_e    memOp_i;
	sqIdx_t    memLsqId_i;
	addr_t     memAddr_i;
	data_t     memData_i;
	logic      commitLoad_i;
	logic      commitStore_i;
	logic      ldEn_o;
	addr_t     ldAddr_o;
	data_t     ldData_i;
	logic      stEn_o;
	addr_t     stAddr_o;
	data_t     stData_o;
	logic      wbValid_o;
	lqIdx_t    wbLsqId_o;
	data_t     wbData_o;
	logic      ldVioValid_o;
	lqIdx_t    ldVioLsqId_o;
	lsqCount_t ldqCount_o;
	lsqCount_t stqCount_o;

	data_t mem    [16];     // memory behind the lsu
	data_t refMem [16];     // what memory should hold after commits

	// model of both queues indexed like the dut
	logic  stqValid [`LSU_SQ_DEPTH];
	logic  stqKnown [`LSU_SQ_DEPTH];
	addr_t stqAddr  [`LSU_SQ_DEPTH];
	data_t stqData  [`LSU_SQ_DEPTH];
	int    stqSeq   [`LSU_SQ_DEPTH];   // program order number
	logic  ldqValid [`LSU_LQ_DEPTH];
	logic  ldqExec  [`LSU_LQ_DEPTH];
	addr_t ldqAddr  [`LSU_LQ_DEPTH];
	int    ldqSeq   [`LSU_LQ_DEPTH];
	int    sqHeadM, sqTailM, sqCountM;
	int    lqHeadM, lqTailM, lqCountM;
	int    seqCount;

	// results still owed by the dut
	int     expLdDue[$];
	addr_t  expLdAddr[$];
	int     expWbDue[$];
	lqIdx_t expWbId[$];
	data_t  expWbData[$];
	int     expVioDue[$];
	lqIdx_t expVioId[$];

	int          cyc = 0;
	int          errors = 0;
	int          testsRun = 0;
	int          testsFailed = 0;
	int          errBefore;
	int          vioCount = 0;
	int unsigned lcgState = 79;

	loadStoreUnit dut0 (
		.clk             (clk),
		.reset           (reset),
		.recoverFlag_i   (recoverFlag_i),
		.dispatchValid_i (dispatchValid_i),
		.dispatchOp_i    (dispatchOp_i),
		.lsqId_o         (lsqId_o),
		.memValid_i      (memValid_i),
		.memOp_i         (memOp_i),
		.memLsqId_i      (memLsqId_i),
		.memAddr_i       (memAddr_i),
		.memData_i       (memData_i),
		.commitLoad_i    (commitLoad_i),
		.commitStore_i   (commitStore_i),
		.ldEn_o          (ldEn_o),
		.ldAddr_o        (ldAddr_o),
		.ldData_i        (ldData_i),
		.stEn_o          (stEn_o),
		.stAddr_o        (stAddr_o),
		.stData_o        (stData_o),
		.wbValid_o       (wbValid_o),
		.wbLsqId_o       (wbLsqId_o),
		.wbData_o        (wbData_o),
		.ldVioValid_o    (ldVioValid_o),
		.ldVioLsqId_o    (ldVioLsqId_o),
		.ldqCount_o      (ldqCount_o),
		.stqCount_o      (stqCount_o)
	);

	always #4 clk = ~clk;   // 8 ns period

	always @(posedge clk)
		cyc <= cyc + 1;

	// synchronous memory with read data one cycle after ldEn_o
	always @(posedge clk)
	begin
		if (ldEn_o)
			ldData_i <= mem[ldAddr_o[3:0]];
		if (stEn_o)
			mem[stAddr_o[3:0]] <= stData_o;
	end

	function automatic int unsigned nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic data_t fillWord(input int a);
		return 32'hC0DE_0000 + a * 32'h0101_0111;   // differs for every word
	endfunction

	// four word addresses shared by all tests
	function automatic addr_t poolAddr(input int unsigned idx);
		case (idx % 4)
			0:       return addr_t'(3);
			1:       return addr_t'(6);
			2:       return addr_t'(9);
			default: return addr_t'(13);
		endcase
	endfunction

	function automatic addr_t randAddr();
		return poolAddr(nextRand() >> 16);
	endfunction

	function automatic addr_t otherAddr(input addr_t a);
		return (a == poolAddr(0)) ? poolAddr(1) : poolAddr(0);
	endfunction

	// youngest older store with a known matching address or else memory
	function automatic data_t expectedLoad(input int loadSeq, input addr_t addr);
		int    bestSeq;
		data_t val;
		bestSeq = -1;
		val     = refMem[addr[3:0]];
		for (int i = 0; i < `LSU_SQ_DEPTH; i++)
			if (stqValid[i] && stqKnown[i] && stqSeq[i] < loadSeq &&
				stqAddr[i] == addr && stqSeq[i] > bestSeq)
			begin
				bestSeq = stqSeq[i];
				val     = stqData[i];
			end
		return val;
	endfunction

	// oldest executed younger load at the same address or -1
	function automatic int expectedVio(input int storeSeq, input addr_t addr);
		int idx;
		for (int k = 0; k < lqCountM; k++)
		begin
			idx = (lqHeadM + k) % `LSU_LQ_DEPTH;
			if (ldqValid[idx] && ldqExec[idx] && ldqSeq[idx] > storeSeq && ldqAddr[idx] == addr)
				return idx;
		end
		return -1;
	endfunction

	// compares every read request, writeback and violation against what is owed
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (expLdDue.size() > 0 && expLdDue[0] <= cyc)
			begin
				assert (ldEn_o && ldAddr_o == expLdAddr[0])
				else
				begin
					$display("error at %0t ns: ldEn_o/ldAddr_o is %b/%0d, expected 1/%0d",
						$time, ldEn_o, ldAddr_o, expLdAddr[0]);
					errors++;
				end
				void'(expLdDue.pop_front());
				void'(expLdAddr.pop_front());
			end
			else
			begin
				assert (!ldEn_o)
				else
				begin
					$display("error at %0t ns: ldEn_o is 1, expected 0", $time);
					errors++;
				end
			end

			if (expWbDue.size() > 0 && expWbDue[0] <= cyc)
			begin
				assert (wbValid_o)
				else
				begin
					$display("load %0d gave no writeback when due at %0t ns", expWbId[0], $time);
					errors++;
				end
				if (wbValid_o)
				begin
					assert (wbLsqId_o == expWbId[0])
					else
					begin
						$display("error at %0t ns: wbLsqId_o is %0d, expected %0d",
							$time, wbLsqId_o, expWbId[0]);
						errors++;
					end
					assert (wbData_o == expWbData[0])
					else
					begin
						$display("error at %0t ns: wbData_o is %h, expected %h",
							$time, wbData_o, expWbData[0]);
						errors++;
					end
				end
				void'(expWbDue.pop_front());
				void'(expWbId.pop_front());
				void'(expWbData.pop_front());
			end
			else
			begin
				assert (!wbValid_o)
				else
				begin
					$display("error at %0t ns: wbValid_o is 1, expected 0", $time);
					errors++;
				end
			end

			if (expVioDue.size() > 0 && expVioDue[0] <= cyc)
			begin
				assert (ldVioValid_o && ldVioLsqId_o == expVioId[0])
				else
				begin
					$display("error at %0t ns: ldVioValid_o/ldVioLsqId_o is %b/%0d, expected 1/%0d",
						$time, ldVioValid_o, ldVioLsqId_o, expVioId[0]);
					errors++;
				end
				if (ldVioValid_o)
					vioCount++;
				void'(expVioDue.pop_front());
				void'(expVioId.pop_front());
			end
			else
			begin
				assert (!ldVioValid_o)
				else
				begin
					$display("error at %0t ns: ldVioValid_o is 1, expected 0", $time);
					errors++;
				end
			end
		end
	end

	// one dispatch with its id checked in the dispatch cycle
	task automatic dispatchOne(input lsuOp_e op, output int id);
		@(posedge clk);
		dispatchValid_i <= 1'b1;
		dispatchOp_i    <= op;
		@(posedge clk);
		id = (op == opStore) ? sqTailM : lqTailM;
		assert (lsqId_o == sqIdx_t'(id))
		else
		begin
			$display("error at %0t ns: lsqId_o is %0d, expected %0d", $time, lsqId_o, id);
			errors++;
		end
		dispatchValid_i <= 1'b0;
		if (op == opStore)
		begin
			stqValid[id] = 1'b1;
			stqKnown[id] = 1'b0;
			stqSeq[id]   = seqCount;
			sqTailM      = (sqTailM + 1) % `LSU_SQ_DEPTH;
			sqCountM++;
		end
		else
		begin
			ldqValid[id] = 1'b1;
			ldqExec[id]  = 1'b0;
			ldqSeq[id]   = seqCount;
			lqTailM      = (lqTailM + 1) % `LSU_LQ_DEPTH;
			lqCountM++;
		end
		seqCount++;
	endtask

	// address arrival holding memValid_i until endIssue
	task automatic issueMem(input lsuOp_e op, input int id, input addr_t addr, input data_t data);
		int vio;
		@(posedge clk);
		memValid_i <= 1'b1;
		memOp_i    <= op;
		memLsqId_i <= sqIdx_t'(id);
		memAddr_i  <= addr;
		memData_i  <= data;
		if (op == opLoad)
		begin
			expLdDue.push_back(cyc + 2);    // read request in the cycle after arrival
			expLdAddr.push_back(addr);
			expWbDue.push_back(cyc + 3);    // sampled next edge and result two later
			expWbId.push_back(lqIdx_t'(id));
			expWbData.push_back(expectedLoad(ldqSeq[id], addr));
			ldqExec[id] = 1'b1;
			ldqAddr[id] = addr;
		end
		else
		begin
			vio = expectedVio(stqSeq[id], addr);
			if (vio >= 0)
			begin
				expVioDue.push_back(cyc + 2);
				expVioId.push_back(lqIdx_t'(vio));
			end
			stqKnown[id] = 1'b1;
			stqAddr[id]  = addr;
			stqData[id]  = data;
		end
	endtask

	task automatic endIssue();
		@(posedge clk);
		memValid_i <= 1'b0;
	endtask

	task automatic commitOneStore();
		int h;
		h = sqHeadM;
		@(posedge clk);
		commitStore_i <= 1'b1;
		@(posedge clk);
		commitStore_i <= 1'b0;
		assert (!stEn_o)
		else
		begin
			$display("error at %0t ns: stEn_o is 1, expected 0", $time);
			errors++;
		end
		@(posedge clk);     // write shows one cycle after commit
		assert (stEn_o && stAddr_o == stqAddr[h] && stData_o == stqData[h])
		else
		begin
			$display("error at %0t ns: stEn_o/stAddr_o/stData_o is %b/%0d/%h, expected 1/%0d/%h",
				$time, stEn_o, stAddr_o, stData_o, stqAddr[h], stqData[h]);
			errors++;
		end
		refMem[stqAddr[h][3:0]] = stqData[h];
		stqValid[h] = 1'b0;
		sqHeadM     = (h + 1) % `LSU_SQ_DEPTH;
		sqCountM--;
	endtask

	task automatic commitOneLoad();
		@(posedge clk);
		commitLoad_i <= 1'b1;
		@(posedge clk);
		commitLoad_i <= 1'b0;
		ldqValid[lqHeadM] = 1'b0;
		lqHeadM = (lqHeadM + 1) % `LSU_LQ_DEPTH;
		lqCountM--;
	endtask

	task automatic checkCounts();
		@(posedge clk);
		assert (ldqCount_o == lsqCount_t'(lqCountM) && stqCount_o == lsqCount_t'(sqCountM))
		else
		begin
			$display("error at %0t ns: ldqCount_o/stqCount_o is %0d/%0d, expected %0d/%0d",
				$time, ldqCount_o, stqCount_o, lqCountM, sqCountM);
			errors++;
		end
	endtask

	task automatic recoverAll();
		int limit;
		@(posedge clk);
		recoverFlag_i <= 1'b1;
		memValid_i    <= 1'b0;
		limit = cyc + 1;    // anything later than this is cancelled
		while (expLdDue.size() > 0 && expLdDue[$] > limit)
		begin
			void'(expLdDue.pop_back());
			void'(expLdAddr.pop_back());
		end
		while (expWbDue.size() > 0 && expWbDue[$] > limit)
		begin
			void'(expWbDue.pop_back());
			void'(expWbId.pop_back());
			void'(expWbData.pop_back());
		end
		while (expVioDue.size() > 0 && expVioDue[$] > limit)
		begin
			void'(expVioDue.pop_back());
			void'(expVioId.pop_back());
		end
		@(posedge clk);
		recoverFlag_i <= 1'b0;
		for (int i = 0; i < `LSU_SQ_DEPTH; i++)
			stqValid[i] = 1'b0;
		for (int i = 0; i < `LSU_LQ_DEPTH; i++)
			ldqValid[i] = 1'b0;
		sqHeadM  = 0;
		sqTailM  = 0;
		sqCountM = 0;
		lqHeadM  = 0;
		lqTailM  = 0;
		lqCountM = 0;
	endtask

	// until every owed result has come back
	task automatic waitDrained();
		int n;
		n = 0;
		while ((expLdDue.size() > 0 || expWbDue.size() > 0 || expVioDue.size() > 0) &&
			n < 40)
		begin
			@(posedge clk);
			n++;
		end
		if (n >= 40)
		begin
			$display("timed out waiting for load results at %0t ns", $time);
			errors++;
		end
	endtask

	task automatic retireAll();
		while (sqCountM > 0)
			commitOneStore();
		while (lqCountM > 0)
			commitOneLoad();
		checkCounts();
	endtask

	task automatic reportTest(input int num, input string name);
		testsRun++;
		if (errors != errBefore)
			testsFailed++;
		$display("test %0d %s: %s", num, name, (errors == errBefore) ? "ok" : "errors");
		errBefore = errors;
	endtask

	initial
	begin
		#200000;
		$display("watchdog expired, simulation did not finish");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		int    s0, s1, l0, l1;
		int    ids[5];
		addr_t a, b;
		reset           = 1'b1;
		recoverFlag_i   = 1'b0;
		dispatchValid_i = 1'b0;
		dispatchOp_i    = opLoad;
		memValid_i      = 1'b0;
		memOp_i         = opLoad;
		memLsqId_i      = '0;
		memAddr_i       = '0;
		memData_i       = '0;
		commitLoad_i    = 1'b0;
		commitStore_i   = 1'b0;
		ldData_i        = '0;
		for (int i = 0; i < 16; i++)
		begin
			mem[i]    = fillWord(i);
			refMem[i] = fillWord(i);
		end
		for (int i = 0; i < `LSU_SQ_DEPTH; i++)
			stqValid[i] = 1'b0;
		for (int i = 0; i < `LSU_LQ_DEPTH; i++)
			ldqValid[i] = 1'b0;
		{sqHeadM, sqTailM, sqCountM, lqHeadM, lqTailM, lqCountM} = '0;
		seqCount  = 0;
		errBefore = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		assert (!ldEn_o && !stEn_o && !wbValid_o && !ldVioValid_o &&
			ldqCount_o == '0 && stqCount_o == '0)
		else
		begin
			$display("outputs not idle after reset");
			errors++;
		end

		// two older stores to one word where the younger one wins
		a = randAddr();
		dispatchOne(opStore, s0);
		dispatchOne(opStore, s1);
		dispatchOne(opLoad, l0);
		issueMem(opStore, s0, a, nextRand());
		issueMem(opStore, s1, a, nextRand());
		issueMem(opLoad, l0, a, '0);
		endIssue();
		waitDrained();
		retireAll();
		reportTest(1, "forwarding");

		// plain memory reads back to back
		dispatchOne(opLoad, l0);
		dispatchOne(opLoad, l1);
		issueMem(opLoad, l0, poolAddr(0), '0);
		issueMem(opLoad, l1, poolAddr(1), '0);
		endIssue();
		waitDrained();
		retireAll();
		reportTest(2, "memory read");

		// younger known store and older unknown store skipped
		a = randAddr();
		b = otherAddr(a);
		dispatchOne(opStore, s0);
		dispatchOne(opLoad, l0);
		dispatchOne(opStore, s1);
		issueMem(opStore, s1, a, nextRand());
		issueMem(opLoad, l0, a, '0);
		issueMem(opStore, s0, b, nextRand());   // resolves elsewhere so no vio
		endIssue();
		waitDrained();
		retireAll();
		reportTest(3, "younger stores");

		// load ran ahead of an older store to the same word
		a = randAddr();
		b = otherAddr(a);
		l1 = vioCount;
		dispatchOne(opStore, s0);
		dispatchOne(opLoad, l0);
		issueMem(opLoad, l0, a, '0);
		issueMem(opStore, s0, a, nextRand());
		endIssue();
		dispatchOne(opStore, s1);
		dispatchOne(opLoad, l0);
		issueMem(opLoad, l0, a, '0);
		issueMem(opStore, s1, b, nextRand());
		endIssue();
		waitDrained();
		assert (vioCount - l1 == 1)
		else
		begin
			$display("error at %0t ns: violation count is %0d, expected 1", $time, vioCount - l1);
			errors++;
		end
		retireAll();
		reportTest(4, "violation");

		// random stores committed in order against the memory model
		for (int k = 0; k < 5; k++)
		begin
			dispatchOne(opStore, ids[k]);
			checkCounts();
		end
		dispatchOne(opLoad, l0);
		checkCounts();
		for (int k = 0; k < 5; k++)
			issueMem(opStore, ids[k], randAddr(), nextRand());
		issueMem(opLoad, l0, randAddr(), '0);
		endIssue();
		waitDrained();
		for (int k = 0; k < 5; k++)
		begin
			commitOneStore();
			checkCounts();
		end
		commitOneLoad();
		checkCounts();
		for (int i = 0; i < 16; i++)
			assert (mem[i] == refMem[i])
			else
			begin
				$display("error at %0t ns: mem[%0d] is %h, expected %h", $time, i, mem[i], refMem[i]);
				errors++;
			end
		reportTest(5, "commit");

		// recovery with a load in flight and then a fresh start
		a = randAddr();
		dispatchOne(opStore, s0);
		dispatchOne(opLoad, l0);
		dispatchOne(opLoad, l1);
		issueMem(opStore, s0, a, nextRand());
		issueMem(opLoad, l0, a, '0);
		recoverAll();
		checkCounts();
		repeat (6) @(posedge clk);  // any stray writeback is caught here
		dispatchOne(opStore, s0);
		dispatchOne(opLoad, l0);
		issueMem(opStore, s0, a, nextRand());
		issueMem(opLoad, l0, a, '0);
		endIssue();
		waitDrained();
		retireAll();
		reportTest(6, "recovery");

		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end
endmodule

`default_nettype wire

/* project.f */
+incdir+include
verilog/lsuPkg.sv
verilog/lsuControl.sv
verilog/storeQueue.sv
verilog/loadQueue.sv
verilog/loadPipe.sv
verilog/loadStoreUnit.sv
tests/lsuTb.sv
